//--- build.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_retire_stage.sv
rv_exec_top.sv
tb_rv_exec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute slice testbench with verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_exec \
    -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_exec 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" <<< "$output"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::decode_t dec,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    output rv_pkg::word_t   result,
    output logic            branch_cond
);
    import rv_pkg::*;

    word_t    a;
    word_t    b;
    logic [4:0] shamt;

    assign a     = rs1_data;
    assign b     = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = b[4:0];

    always_comb begin
        result      = '0;
        branch_cond = 1'b0;    // only branch ops raise it
        case (dec.alu_op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            SLL: begin
                result = a << shamt;
            end
            SLT: begin
                result[0] = $signed(a) < $signed(b);
            end
            SLTU: begin
                result[0] = a < b;
            end
            XOR: begin
                result = a ^ b;
            end
            SRL: begin
                result = a >> shamt;
            end
            SRA: begin
                result = $signed(a) >>> shamt;
            end
            OR: begin
                result = a | b;
            end
            AND: begin
                result = a & b;
            end
            BEQ:  branch_cond = (a == b);
            BNE:  branch_cond = (a != b);
            BLT:  branch_cond = ($signed(a) < $signed(b));
            BGE:  branch_cond = ($signed(a) >= $signed(b));
            BLTU: branch_cond = (a < b);
            BGEU: branch_cond = (a >= b);
            PASS_B: begin
                result = b;    // lui
            end
            default: begin
            end
        endcase
    end

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder #(
    parameter int REG_COUNT = 32
) (
    input  rv_pkg::word_t   instr,
    output rv_pkg::decode_t dec
);
    import rv_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // sub, sra

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rs1;
    logic       use_rs2;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec        = '0;
        dec.alu_op = ADD;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec.rd_we = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: dec.alu_op = ADD;
                    {F7_ALT,  3'b000}: dec.alu_op = SUB;
                    {F7_BASE, 3'b001}: dec.alu_op = SLL;
                    {F7_BASE, 3'b010}: dec.alu_op = SLT;
                    {F7_BASE, 3'b011}: dec.alu_op = SLTU;
                    {F7_BASE, 3'b100}: dec.alu_op = XOR;
                    {F7_BASE, 3'b101}: dec.alu_op = SRL;
                    {F7_ALT,  3'b101}: dec.alu_op = SRA;
                    {F7_BASE, 3'b110}: dec.alu_op = OR;
                    {F7_BASE, 3'b111}: dec.alu_op = AND;
                    default:           dec.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1     = 1'b1;
                dec.rd_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;    // shifts only look at bits 4:0
                case (funct3)
                    3'b000: dec.alu_op = ADD;
                    3'b010: dec.alu_op = SLT;
                    3'b011: dec.alu_op = SLTU;
                    3'b100: dec.alu_op = XOR;
                    3'b110: dec.alu_op = OR;
                    3'b111: dec.alu_op = AND;
                    3'b001: begin
                        dec.alu_op  = SLL;
                        dec.illegal = (funct7 != F7_BASE);
                    end
                    default: begin    // 3'b101
                        if (funct7 == F7_BASE) begin
                            dec.alu_op = SRL;
                        end else if (funct7 == F7_ALT) begin
                            dec.alu_op = SRA;
                        end else begin
                            dec.illegal = 1'b1;
                        end
                    end
                endcase
            end
            OPC_LUI: begin
                dec.rd_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = PASS_B;
            end
            OPC_BRANCH: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.is_branch = 1'b1;
                dec.imm       = imm_b;    // branch target offset
                case (funct3)
                    3'b000:  dec.alu_op = BEQ;
                    3'b001:  dec.alu_op = BNE;
                    3'b100:  dec.alu_op = BLT;
                    3'b101:  dec.alu_op = BGE;
                    3'b110:  dec.alu_op = BLTU;
                    3'b111:  dec.alu_op = BGEU;
                    default: dec.illegal = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;
        endcase

        // unused fields read as x0
        dec.rs1 = use_rs1 ? instr[19:15] : '0;
        dec.rs2 = use_rs2 ? instr[24:20] : '0;
        dec.rd  = dec.rd_we ? instr[11:7] : '0;

        // rv32e has fewer registers
        if (dec.rs1 >= REG_COUNT || dec.rs2 >= REG_COUNT || dec.rd >= REG_COUNT) begin
            dec.illegal = 1'b1;
        end
        if (dec.illegal) begin
            dec.rd_we = 1'b0;
            dec.rd    = '0;
        end
    end

endmodule

//--- rv_exec_top.sv
`timescale 1ns/1ns

module rv_exec_top #(
    parameter int REG_COUNT = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  rv_pkg::issue_t  issue,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    decode_t  dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    logic     branch_cond;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    rv_decoder #(.REG_COUNT(REG_COUNT)) u_decoder (
        .instr (issue.instr),
        .dec   (dec)
    );

    rv_regfile #(.REG_COUNT(REG_COUNT)) u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (dec.rs1),
        .rs2_idx  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    rv_alu u_alu (
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .result      (alu_result),
        .branch_cond (branch_cond)
    );

    rv_retire_stage u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .pc           (issue.pc),
        .dec          (dec),
        .alu_result   (alu_result),
        .branch_cond  (branch_cond),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

//--- rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;    // register values, immediates, pcs
    typedef logic [4:0]  reg_idx_t;

    // alu operations, branch ops only drive the condition flag
    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        SLL    = 5'd2,
        SLT    = 5'd3,
        SLTU   = 5'd4,
        XOR    = 5'd5,
        SRL    = 5'd6,
        SRA    = 5'd7,
        OR     = 5'd8,
        AND    = 5'd9,
        BEQ    = 5'd10,
        BNE    = 5'd11,
        BLT    = 5'd12,
        BGE    = 5'd13,
        BLTU   = 5'd14,
        BGEU   = 5'd15,
        PASS_B = 5'd16    // lui
    } alu_op_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } issue_t;

    typedef struct packed {
        alu_op_t  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     use_imm;    // b operand from imm instead of rs2
        logic     rd_we;
        logic     is_branch;
        logic     illegal;
    } decode_t;

    // one record per retired instruction
    typedef struct packed {
        word_t    pc;
        word_t    next_pc;
        reg_idx_t rd;
        word_t    rd_data;
        logic     rd_we;
        logic     branch_taken;
        logic     illegal;
    } retire_t;

endpackage

//--- rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wr_en,
    input  rv_pkg::reg_idx_t wr_idx,
    input  rv_pkg::word_t    wr_data
);
    import rv_pkg::*;

    word_t regs [1:REG_COUNT-1];    // x0 not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // async read, x0 and out of range give zero
    assign rs1_data = (rs1_idx == '0 || rs1_idx >= REG_COUNT) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0 || rs2_idx >= REG_COUNT) ? '0 : regs[rs2_idx];

    a_wr_idx_ok: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_idx != '0 && wr_idx < REG_COUNT)
    ) else $error("regfile: write to x0 or beyond REG_COUNT");

endmodule

//--- rv_retire_stage.sv
`timescale 1ns/1ns

module rv_retire_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue_valid,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::decode_t  dec,
    input  rv_pkg::word_t    alu_result,
    input  logic             branch_cond,
    output logic             wr_en,
    output rv_pkg::reg_idx_t wr_idx,
    output rv_pkg::word_t    wr_data,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire
);
    import rv_pkg::*;

    logic  branch_taken;
    word_t next_pc;

    assign branch_taken = dec.is_branch & branch_cond & ~dec.illegal;
    assign next_pc      = pc + (branch_taken ? dec.imm : 32'd4);

    // writeback lands on the same edge as the retire record
    assign wr_en   = issue_valid & dec.rd_we & (dec.rd != '0);
    assign wr_idx  = dec.rd;
    assign wr_data = alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire       <= '0;
        end else begin
            retire_valid <= issue_valid;
            if (issue_valid) begin
                retire.pc           <= pc;
                retire.next_pc      <= next_pc;
                retire.rd           <= dec.rd;
                retire.rd_data      <= dec.illegal ? '0 : alu_result;
                retire.rd_we        <= dec.rd_we;
                retire.branch_taken <= branch_taken;
                retire.illegal      <= dec.illegal;
            end
        end
    end

    // fixed one-cycle latency, no stray retire
    a_one_retire: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid ##1 !issue_valid |=> !retire_valid
    ) else $error("retire: strobe without a matching issue");

endmodule

//--- tb_rv_exec.sv
`timescale 1ns/1ns

module tb_rv_exec;
    import rv_pkg::*;

    logic    clk;
    logic    rst_n;
    logic    issue_valid;
    issue_t  issue;
    logic    retire_valid;
    retire_t retire;

    logic [31:0][31:0] model;    // architectural registers as the model sees them
    retire_t     exp_q [$];
    int unsigned cyc_q [$];
    word_t       prog_q [$];
    word_t       cur_pc;
    int unsigned cycle;
    int          checks;
    int          errors;
    int          tests_run;
    int          mark_checks;
    int          mark_errors;

    rv_exec_top #(.REG_COUNT(32)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t lui_op(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // rv32i arithmetic by funct3 with alt picking sub or sra
    function automatic word_t alu_expect(input logic [2:0] f3, input logic alt,
                                         input word_t a, input word_t b);
        word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else     res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic retire_t exec_model(input word_t pc, input word_t instr,
                                           inout logic [31:0][31:0] regs);
        retire_t    r;
        logic [6:0] f7;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      boff;
        logic       legal;
        logic       we;
        logic       taken;
        f7    = instr[31:25];
        f3    = instr[14:12];
        a     = regs[instr[19:15]];
        b     = regs[instr[24:20]];
        boff  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        legal = 1'b1;
        we    = 1'b0;
        taken = 1'b0;
        res   = '0;
        case (instr[6:0])
            7'b0110011: begin
                we = 1'b1;
                if (f7 == 7'h20) legal = (f3 == 3'd0 || f3 == 3'd5);
                else             legal = (f7 == 7'h00);
                res = alu_expect(f3, f7[5], a, b);
            end
            7'b0010011: begin
                we = 1'b1;
                if (f3 == 3'd1)      legal = (f7 == 7'h00);
                else if (f3 == 3'd5) legal = (f7 == 7'h00 || f7 == 7'h20);
                res = alu_expect(f3, f3 == 3'd5 && f7[5], a, {{20{instr[31]}}, instr[31:20]});
            end
            7'b0110111: begin
                we  = 1'b1;
                res = {instr[31:12], 12'h000};
            end
            7'b1100011: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        r              = '0;
        r.pc           = pc;
        r.illegal      = !legal;
        r.branch_taken = legal && taken;
        r.next_pc      = r.branch_taken ? pc + boff : pc + 32'd4;
        if (legal) begin
            r.rd_we   = we;
            r.rd      = we ? instr[11:7] : 5'd0;
            r.rd_data = res;
            if (we && instr[11:7] != 5'd0) regs[instr[11:7]] = res;
        end
        return r;
    endfunction

    task automatic issue_one(input word_t instr);
        exp_q.push_back(exec_model(cur_pc, instr, model));
        cyc_q.push_back(cycle);
        issue_valid = 1'b1;
        issue.pc    = cur_pc;
        issue.instr = instr;
        cur_pc      = cur_pc + 32'd4;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic drain_retires();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Error at %0t: timeout, %0d retire records never arrived",
                     $time, exp_q.size());
            exp_q.delete();
            cyc_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    // gap inserts an idle cycle after each strobe
    task automatic run_list(input bit gap);
        foreach (prog_q[i]) begin
            issue_one(prog_q[i]);
            if (gap) begin
                @(posedge clk);
                #1;
            end
        end
        prog_q.delete();
        drain_retires();
    endtask

    task automatic read_all();
        for (int k = 0; k < 32; k++) prog_q.push_back(r_type(7'h00, 5'd0, 5'(k), 3'd0, 5'd0));
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %-10s done: %0d checks, %0d errors", name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic random_chain(input int count);
        reg_idx_t    prev;
        reg_idx_t    rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        prev = 5'd1;
        for (int i = 0; i < count; i++) begin
            rd   = 5'($urandom_range(31, 1));
            f3   = 3'($urandom % 8);
            kind = $urandom % 8;
            if (kind < 3) begin
                prog_q.push_back(r_type(((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ?
                                        7'h20 : 7'h00, 5'($urandom % 32), prev, f3, rd));
            end else if (kind < 7) begin
                imm = 12'($urandom);
                if (f3 == 3'd1)      imm[11:5] = 7'h00;
                else if (f3 == 3'd5) imm[11:5] = ($urandom % 2) ? 7'h20 : 7'h00;
                prog_q.push_back(i_type(imm, prev, f3, rd));
            end else begin
                prog_q.push_back(lui_op(20'($urandom), rd));
            end
            prev = rd;    // next one depends on this result
        end
        run_list(1'b0);
    endtask

    // compare each retire against the oldest expectation
    initial begin
        retire_t     want;
        int unsigned icyc;
        forever begin
            @(negedge clk);
            if (rst_n && retire_valid) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("Error at %0t: retire strobe with no instruction issued", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    icyc = cyc_q.pop_front();
                    assert (retire == want) else begin
                        errors++;
                        $write("Mismatch at %0t: got/exp pc %h/%h next %h/%h rd %0d/%0d ",
                               $time, retire.pc, want.pc, retire.next_pc, want.next_pc,
                               retire.rd, want.rd);
                        $display("data %h/%h we %b/%b tk %b/%b il %b/%b",
                                 retire.rd_data, want.rd_data, retire.rd_we, want.rd_we,
                                 retire.branch_taken, want.branch_taken,
                                 retire.illegal, want.illegal);
                    end
                    assert (cycle == icyc + 1) else begin
                        errors++;
                        $display("Mismatch at %0t: pc %h retired %0d cycles after issue",
                                 $time, want.pc, cycle - icyc);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h12b9));
        model       = '0;
        cur_pc      = 32'h0000_1000;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        tests_run   = 0;
        mark_checks = 0;
        mark_errors = 0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (5) begin
            @(negedge clk);
            checks++;
            assert (!retire_valid) else begin
                errors++;
                $display("Error at %0t: retire strobe seen with no issue after reset", $time);
            end
        end
        @(posedge clk);
        #1;
        read_all();
        run_list(1'b0);
        report_test("reset");

        prog_q = '{lui_op(20'h87654, 5'd1), i_type(12'h321, 5'd1, 3'd0, 5'd1),
                   i_type(12'hff0, 5'd0, 3'd0, 5'd2), i_type(12'd100, 5'd0, 3'd0, 5'd3)};
        for (int f = 0; f < 8; f++) begin
            prog_q.push_back(r_type(7'h00, 5'd3, 5'd1, 3'(f), 5'(4 + f)));
            prog_q.push_back(r_type(7'h00, 5'd3, 5'd2, 3'(f), 5'(12 + f)));    // negative rs1
            prog_q.push_back(i_type(f == 1 || f == 5 ? 12'd7 : 12'h9a5, 5'd2, 3'(f), 5'(20 + f)));
        end
        prog_q.push_back(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd28));    // sub
        prog_q.push_back(r_type(7'h20, 5'd3, 5'd2, 3'd5, 5'd29));    // sra of a negative value
        prog_q.push_back(i_type({7'h20, 5'd2}, 5'd2, 3'd5, 5'd30));
        prog_q.push_back(r_type(7'h00, 5'd3, 5'd2, 3'd2, 5'd31));    // slt vs sltu on mixed signs
        prog_q.push_back(r_type(7'h00, 5'd3, 5'd2, 3'd3, 5'd31));
        run_list(1'b1);
        report_test("arith");

        prog_q = '{i_type(12'hffd, 5'd0, 3'd0, 5'd1), i_type(12'd5, 5'd0, 3'd0, 5'd2),
                   i_type(12'd5, 5'd0, 3'd0, 5'd3)};
        foreach (prog_q[i]) issue_one(prog_q[i]);
        prog_q.delete();
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                prog_q.push_back(b_type(13'd16, 5'd2, 5'd1, 3'(f)));
                prog_q.push_back(b_type(13'h1ff8, 5'd3, 5'd2, 3'(f)));    // backward
                prog_q.push_back(b_type(13'd256, 5'd1, 5'd2, 3'(f)));
            end
        end
        run_list(1'b1);
        report_test("branch");

        prog_q = '{i_type(12'd55, 5'd0, 3'd0, 5'd0), r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0),
                   lui_op(20'habcde, 5'd0), r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd5),
                   r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd0)};
        run_list(1'b0);
        report_test("x0_write");

        random_chain(80);
        read_all();
        run_list(1'b0);
        report_test("random");

        prog_q = '{i_type(12'd77, 5'd0, 3'd0, 5'd9), {12'h123, 5'd1, 3'd0, 5'd9, 7'h7f},
                   i_type({7'h20, 5'd3}, 5'd1, 3'd1, 5'd9), i_type({7'h10, 5'd3}, 5'd1, 3'd5, 5'd9),
                   r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd9), b_type(13'd8, 5'd2, 5'd1, 3'd2),
                   r_type(7'h00, 5'd0, 5'd9, 3'd0, 5'd0)};
        run_list(1'b1);
        report_test("illegal");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
